// ==== rv_consts.svh ====
// shared constants for the RV32I execute subsystem
// data and register address widths, ALU operator codes
// RV32I major opcodes, funct3 and funct7 values
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// widths
`define XLEN        32
`define REG_ADDR_W  5
`define ALU_OP_W    4
`define SHAMT_W     5

////////////////////////////////////////
// ALU operator codes
////////////////////////////////////////
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_XOR   4'd2
`define ALU_OR    4'd3
`define ALU_AND   4'd4
`define ALU_SLL   4'd5
`define ALU_SRL   4'd6
`define ALU_SRA   4'd7
// branch comparisons
`define ALU_EQ    4'd8
`define ALU_NE    4'd9
`define ALU_LTS   4'd10
`define ALU_LTU   4'd11
`define ALU_GES   4'd12
`define ALU_GEU   4'd13
// set-less-than, result in bit 0
`define ALU_SLTS  4'd14
`define ALU_SLTU  4'd15

////////////////////////////////////////
// RV32I encodings
////////////////////////////////////////
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011

// funct3 of register and immediate ALU forms
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 of the branch conditions
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// funct7, alt selects SUB and SRA
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`endif

// ==== rv_pkg.sv ====
// shared vector types of the RV32I execute subsystem
// data word, instruction word, register index, ALU operator
// instruction field types used by the decoder
`include "rv_consts.svh"

package rv_pkg;

  ////////////////////////////////////////
  // data path types
  ////////////////////////////////////////

  // one data word
  // operands, results, program counter and immediates
  typedef logic [`XLEN-1:0] word_t;

  // one raw instruction word as fetched
  typedef logic [31:0] instr_t;

  // register index, x0 to x31
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // ALU operator code, see ALU_* constants
  typedef logic [`ALU_OP_W-1:0] alu_op_t;

  // shift amount, low bits of operand b
  typedef logic [`SHAMT_W-1:0] shamt_t;

  ////////////////////////////////////////
  // instruction field types
  ////////////////////////////////////////

  // major opcode in bits 6:0
  typedef logic [6:0] opcode_t;

  // minor opcode in bits 14:12
  typedef logic [2:0] funct3_t;

  // upper funct field in bits 31:25
  // also the top of the I immediate for shift forms
  typedef logic [6:0] funct7_t;

endpackage

// ==== rv_decoder.sv ====
// RV32I instruction decoder
// R-type and I-type ALU forms, LUI and the six branches
// immediate generation, operator mapping and branch target
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_decoder
(
  input  rv_pkg::instr_t    instr_i,
  input  rv_pkg::word_t     pc_i,

  output rv_pkg::alu_op_t   alu_op_o,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::reg_addr_t rd_o,
  output rv_pkg::word_t     imm_o,
  output logic              use_imm_o,
  output logic              is_lui_o,
  output logic              is_branch_o,
  output logic              rd_we_o,
  output logic              illegal_o,
  output rv_pkg::word_t     branch_target_o
);

  // instruction fields
  rv_pkg::opcode_t opcode;
  rv_pkg::funct3_t funct3;
  rv_pkg::funct7_t funct7;

  // sign extended immediates
  rv_pkg::word_t   imm_i_type;
  rv_pkg::word_t   imm_b_type;
  rv_pkg::word_t   imm_u_type;

  logic            legal;
  logic            writes_rd;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // register addresses come straight from the word
  assign rd_o  = instr_i[11:7];
  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  // branch offset, bit 0 always zero
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // target computed for every word, only meaningful for branches
  assign branch_target_o = pc_i + imm_b_type;

  ////////////////////////////////////////
  // operator and control decode
  ////////////////////////////////////////

  always_comb
  begin
    alu_op_o    = `ALU_ADD;
    imm_o       = imm_i_type;
    use_imm_o   = 1'b0;
    is_lui_o    = 1'b0;
    is_branch_o = 1'b0;
    writes_rd   = 1'b0;
    legal       = 1'b0;

    case (opcode)
      `OPC_OP, `OPC_OP_IMM:
      begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        use_imm_o = (opcode == `OPC_OP_IMM);

        case (funct3)
          // no SUBI, the immediate form always adds
          `F3_ADD_SUB: alu_op_o = (use_imm_o || funct7 != `F7_ALT) ? `ALU_ADD : `ALU_SUB;
          `F3_SLL:     alu_op_o = `ALU_SLL;
          `F3_SLT:     alu_op_o = `ALU_SLTS;
          `F3_SLTU:    alu_op_o = `ALU_SLTU;
          `F3_XOR:     alu_op_o = `ALU_XOR;
          `F3_SRL_SRA: alu_op_o = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
          `F3_OR:      alu_op_o = `ALU_OR;
          default:     alu_op_o = `ALU_AND;
        endcase

        // funct7 check
        // register form uses funct7 everywhere, immediate form only on shifts
        if (!use_imm_o || funct3 == `F3_SLL || funct3 == `F3_SRL_SRA)
        begin
          if (funct7 == `F7_ALT)
            legal = (funct3 == `F3_SRL_SRA) || (!use_imm_o && funct3 == `F3_ADD_SUB);
          else if (funct7 != `F7_BASE)
            legal = 1'b0;
        end
      end

      `OPC_LUI:
      begin
        legal     = 1'b1;
        writes_rd = 1'b1;
        is_lui_o  = 1'b1;
        imm_o     = imm_u_type;
      end

      `OPC_BRANCH:
      begin
        legal       = 1'b1;
        is_branch_o = 1'b1;
        imm_o       = imm_b_type;

        case (funct3)
          `F3_BEQ:  alu_op_o = `ALU_EQ;
          `F3_BNE:  alu_op_o = `ALU_NE;
          `F3_BLT:  alu_op_o = `ALU_LTS;
          `F3_BGE:  alu_op_o = `ALU_GES;
          `F3_BLTU: alu_op_o = `ALU_LTU;
          `F3_BGEU: alu_op_o = `ALU_GEU;
          // funct3 010 and 011 are reserved
          default:
          begin
            legal       = 1'b0;
            is_branch_o = 1'b0;
          end
        endcase
      end

      // loads, stores, jumps, system and the rest
      default: ;
    endcase
  end

  // x0 is never written
  assign rd_we_o   = legal & writes_rd & (rd_o != '0);
  assign illegal_o = ~legal;

endmodule

// ==== rv_regfile.sv ====
// integer register file, x1 to x31, 32 bits each
// x0 reads as zero, two combinational read ports
// one write port, written on the rising clock edge
`timescale 1ns/100ps

module rv_regfile
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  input  rv_pkg::reg_addr_t raddr_a_i,
  output rv_pkg::word_t     rdata_a_o,
  input  rv_pkg::reg_addr_t raddr_b_i,
  output rv_pkg::word_t     rdata_b_o,

  input  logic              we_i,
  input  rv_pkg::reg_addr_t waddr_i,
  input  rv_pkg::word_t     wdata_i
);

  // no storage for x0
  rv_pkg::word_t regs [1:31];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we_i && waddr_i != '0)
    begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // read ports, zero for x0
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// ==== rv_alu.sv ====
// reduced RV32I ALU
// one 33-bit adder shared by add, sub and all comparisons
// one right shifter, left shifts through bit reversal
// result multiplexer over logic, adder, shift and compare
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_alu
(
  input  rv_pkg::alu_op_t operator_i,
  input  rv_pkg::word_t   operand_a_i,
  input  rv_pkg::word_t   operand_b_i,

  output rv_pkg::word_t   result_o,
  output logic            comparison_result_o
);

  ////////////////////////////////////////
  // adder
  ////////////////////////////////////////

  logic                  negate_b;
  logic [`XLEN:0]        adder_in_a;
  logic [`XLEN:0]        adder_in_b;
  logic [`XLEN:0]        adder_sum;
  rv_pkg::word_t         adder_result;

  // everything except ADD subtracts
  always_comb
  begin
    case (operator_i)
      `ALU_SUB,
      `ALU_EQ,   `ALU_NE,
      `ALU_LTS,  `ALU_LTU,
      `ALU_GES,  `ALU_GEU,
      `ALU_SLTS, `ALU_SLTU: negate_b = 1'b1;
      default:              negate_b = 1'b0;
    endcase
  end

  // extra low bit carries the +1 of the two's complement
  // a 1 on a and an inverted 0 on b give the carry in
  assign adder_in_a   = {operand_a_i, 1'b1};
  assign adder_in_b   = {operand_b_i, 1'b0} ^ {(`XLEN+1){negate_b}};
  assign adder_sum    = adder_in_a + adder_in_b;
  assign adder_result = adder_sum[`XLEN:1];

  ////////////////////////////////////////
  // shifter
  ////////////////////////////////////////

  logic                  shift_left;
  logic                  shift_arith;
  rv_pkg::shamt_t        shift_amt;
  rv_pkg::word_t         operand_a_rev;
  rv_pkg::word_t         shift_in;
  logic [`XLEN:0]        shift_in_ext;
  rv_pkg::word_t         shift_right;
  rv_pkg::word_t         shift_right_rev;
  rv_pkg::word_t         shift_result;

  assign shift_left  = (operator_i == `ALU_SLL);
  assign shift_arith = (operator_i == `ALU_SRA);
  // only the low five bits count
  assign shift_amt   = operand_b_i[`SHAMT_W-1:0];

  // bit reversal on the way in and out of the shifter
  for (genvar k = 0; k < `XLEN; k++)
  begin : g_rev
    assign operand_a_rev[k]   = operand_a_i[`XLEN-1-k];
    assign shift_right_rev[k] = shift_right[`XLEN-1-k];
  end

  assign shift_in = shift_left ? operand_a_rev : operand_a_i;

  // top bit fills with the sign for SRA, zero otherwise
  assign shift_in_ext = {shift_arith & shift_in[`XLEN-1], shift_in};

  always_comb
  begin
    shift_right = rv_pkg::word_t'($signed(shift_in_ext) >>> shift_amt);
  end

  assign shift_result = shift_left ? shift_right_rev : shift_right;

  ////////////////////////////////////////
  // comparator
  ////////////////////////////////////////

  logic                  cmp_signed;
  logic                  is_equal;
  logic                  is_greater_equal;
  logic                  cmp_result;

  assign cmp_signed = (operator_i == `ALU_LTS) || (operator_i == `ALU_GES) ||
                      (operator_i == `ALU_SLTS);

  // a - b is zero
  assign is_equal = (adder_result == '0);

  // same top bits, the sign of a - b decides
  // differing top bits, a is the larger one unsigned and the smaller one signed
  always_comb
  begin
    if (operand_a_i[`XLEN-1] == operand_b_i[`XLEN-1])
      is_greater_equal = ~adder_result[`XLEN-1];
    else
      is_greater_equal = operand_a_i[`XLEN-1] ^ cmp_signed;
  end

  always_comb
  begin
    case (operator_i)
      `ALU_EQ:             cmp_result = is_equal;
      `ALU_NE:             cmp_result = ~is_equal;
      `ALU_GES, `ALU_GEU:  cmp_result = is_greater_equal;
      `ALU_LTS, `ALU_LTU,
      `ALU_SLTS, `ALU_SLTU: cmp_result = ~is_greater_equal;
      default:             cmp_result = 1'b0;
    endcase
  end

  assign comparison_result_o = cmp_result;

  ////////////////////////////////////////
  // result mux
  ////////////////////////////////////////

  always_comb
  begin
    case (operator_i)
      `ALU_AND:            result_o = operand_a_i & operand_b_i;
      `ALU_OR:             result_o = operand_a_i | operand_b_i;
      `ALU_XOR:            result_o = operand_a_i ^ operand_b_i;
      `ALU_ADD, `ALU_SUB:  result_o = adder_result;
      `ALU_SLL, `ALU_SRL,
      `ALU_SRA:            result_o = shift_result;
      // comparisons, 0 or 1 in bit 0
      default:             result_o = {{(`XLEN-1){1'b0}}, cmp_result};
    endcase
  end

endmodule

// ==== rv_commit_stage.sv ====
// commit stage of the execute subsystem
// input acceptance, register file write, outcome register
`timescale 1ns/100ps

module rv_commit_stage
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  // instruction stream and decoded fields
  input  logic              instr_valid_i,
  output logic              instr_ready_o,
  input  rv_pkg::word_t     pc_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic              rd_we_i,
  input  logic              is_lui_i,
  input  logic              is_branch_i,
  input  logic              illegal_i,
  input  rv_pkg::word_t     imm_i,
  input  rv_pkg::word_t     alu_result_i,
  input  logic              cmp_i,
  input  rv_pkg::word_t     target_i,

  // register file write port
  output logic              rf_we_o,
  output rv_pkg::reg_addr_t rf_waddr_o,
  output rv_pkg::word_t     rf_wdata_o,

  // outcome stream
  output logic              wb_valid_o,
  input  logic              wb_ready_i,
  output rv_pkg::word_t     wb_pc_o,
  output logic              wb_we_o,
  output rv_pkg::reg_addr_t wb_rd_o,
  output rv_pkg::word_t     wb_data_o,
  output logic              wb_branch_o,
  output logic              wb_taken_o,
  output rv_pkg::word_t     wb_target_o,
  output logic              wb_illegal_o
);

  logic accept;

  // free slot, or the held outcome leaves on this edge
  assign instr_ready_o = ~wb_valid_o | wb_ready_i;
  assign accept        = instr_valid_i & instr_ready_o;

  // write lands on the accepting edge
  assign rf_we_o    = accept & rd_we_i;
  assign rf_waddr_o = rd_i;
  assign rf_wdata_o = is_lui_i ? imm_i : alu_result_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      wb_valid_o <= 1'b0;
    else if (accept)
      wb_valid_o <= 1'b1;
    else if (wb_ready_i)
      wb_valid_o <= 1'b0;
  end

  // outcome fields, loaded only on acceptance
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      wb_pc_o      <= pc_i;
      wb_we_o      <= rd_we_i;
      wb_rd_o      <= rd_we_i ? rd_i : '0;
      // branches and illegal words carry no data
      wb_data_o    <= (is_branch_i | illegal_i) ? '0 : rf_wdata_o;
      wb_branch_o  <= is_branch_i;
      wb_taken_o   <= is_branch_i & cmp_i;
      wb_target_o  <= is_branch_i ? target_i : '0;
      wb_illegal_o <= illegal_i;
    end
  end

endmodule

// ==== rv_exec_top.sv ====
// top level of the RV32I execute subsystem
// decoder, register file, ALU and commit stage
// operand b selection between register and immediate
`timescale 1ns/100ps

module rv_exec_top
(
  input  logic              clk_i,
  input  logic              rst_n_i,

  // instruction stream
  input  logic              instr_valid_i,
  output logic              instr_ready_o,
  input  rv_pkg::instr_t    instr_i,
  input  rv_pkg::word_t     pc_i,

  // outcome stream
  output logic              wb_valid_o,
  input  logic              wb_ready_i,
  output rv_pkg::word_t     wb_pc_o,
  output logic              wb_we_o,
  output rv_pkg::reg_addr_t wb_rd_o,
  output rv_pkg::word_t     wb_data_o,
  output logic              wb_branch_o,
  output logic              wb_taken_o,
  output rv_pkg::word_t     wb_target_o,
  output logic              wb_illegal_o
);

  // decoder outputs
  rv_pkg::alu_op_t   alu_op;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     imm;
  logic              use_imm;
  logic              is_lui;
  logic              is_branch;
  logic              rd_we;
  logic              illegal;
  rv_pkg::word_t     branch_target;

  // operands and ALU results
  rv_pkg::word_t     rdata_a;
  rv_pkg::word_t     rdata_b;
  rv_pkg::word_t     operand_b;
  rv_pkg::word_t     alu_result;
  logic              cmp_result;

  // register file write port
  logic              rf_we;
  rv_pkg::reg_addr_t rf_waddr;
  rv_pkg::word_t     rf_wdata;

  rv_decoder u_decoder
  (
    .instr_i         (instr_i),
    .pc_i            (pc_i),
    .alu_op_o        (alu_op),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .rd_o            (rd),
    .imm_o           (imm),
    .use_imm_o       (use_imm),
    .is_lui_o        (is_lui),
    .is_branch_o     (is_branch),
    .rd_we_o         (rd_we),
    .illegal_o       (illegal),
    .branch_target_o (branch_target)
  );

  rv_regfile u_regfile
  (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rs1),
    .rdata_a_o (rdata_a),
    .raddr_b_i (rs2),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  // immediate forms replace rs2
  assign operand_b = use_imm ? imm : rdata_b;

  rv_alu u_alu
  (
    .operator_i          (alu_op),
    .operand_a_i         (rdata_a),
    .operand_b_i         (operand_b),
    .result_o            (alu_result),
    .comparison_result_o (cmp_result)
  );

  rv_commit_stage u_commit
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .pc_i          (pc_i),
    .rd_i          (rd),
    .rd_we_i       (rd_we),
    .is_lui_i      (is_lui),
    .is_branch_i   (is_branch),
    .illegal_i     (illegal),
    .imm_i         (imm),
    .alu_result_i  (alu_result),
    .cmp_i         (cmp_result),
    .target_i      (branch_target),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .wb_valid_o    (wb_valid_o),
    .wb_ready_i    (wb_ready_i),
    .wb_pc_o       (wb_pc_o),
    .wb_we_o       (wb_we_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .wb_branch_o   (wb_branch_o),
    .wb_taken_o    (wb_taken_o),
    .wb_target_o   (wb_target_o),
    .wb_illegal_o  (wb_illegal_o)
  );

endmodule

// ==== tb_rv_ref.svh ====
// reference model for the execute subsystem testbench
// shadow register file and the expected outcome of one instruction
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

// architectural registers as the testbench sees them, x0 stays zero
logic [31:0] shadow_regs [0:31];

task automatic clear_shadow();
  for (int i = 0; i < 32; i++)
    shadow_regs[i] = '0;
endtask

// expected outcome fields, shadow registers follow the write
function automatic void predict_outcome
(
  input  logic [31:0] instr,
  input  logic [31:0] pc,
  output logic        exp_we,
  output logic [4:0]  exp_rd,
  output logic [31:0] exp_data,
  output logic        exp_branch,
  output logic        exp_taken,
  output logic [31:0] exp_target,
  output logic        exp_illegal
);
  logic [6:0]  opcode;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_b;
  logic [31:0] value;
  logic        is_imm;
  logic        alt;
  logic        legal;
  logic        branch;
  logic        taken;

  opcode = instr[6:0];
  f3     = instr[14:12];
  rd     = instr[11:7];
  is_imm = (opcode == `OPC_OP_IMM);
  a      = shadow_regs[instr[19:15]];
  // second operand, rs2 or the sign extended I immediate
  b      = is_imm ? {{20{instr[31]}}, instr[31:20]} : shadow_regs[instr[24:20]];
  imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  alt    = (instr[31:25] == `F7_ALT);
  legal  = 1'b0;
  branch = 1'b0;
  taken  = 1'b0;
  value  = '0;

  case (opcode)
    `OPC_LUI:
    begin
      legal = 1'b1;
      value = {instr[31:12], 12'h000};
    end

    `OPC_OP, `OPC_OP_IMM:
    begin
      // funct7 matters for register forms and immediate shifts only
      if (is_imm && f3 != `F3_SLL && f3 != `F3_SRL_SRA)
        legal = 1'b1;
      else
        legal = (instr[31:25] == `F7_BASE) ||
                (alt && (f3 == `F3_SRL_SRA || (!is_imm && f3 == `F3_ADD_SUB)));
      case (f3)
        `F3_ADD_SUB: value = (alt && !is_imm) ? a - b : a + b;
        `F3_SLL:     value = a << b[4:0];
        `F3_SLT:     value = {31'b0, $signed(a) < $signed(b)};
        `F3_SLTU:    value = {31'b0, a < b};
        `F3_XOR:     value = a ^ b;
        `F3_SRL_SRA:
        begin
          // arithmetic form fills with the sign of a
          if (alt)
            value = $signed(a) >>> b[4:0];
          else
            value = a >> b[4:0];
        end
        `F3_OR:      value = a | b;
        default:     value = a & b;
      endcase
    end

    `OPC_BRANCH:
    begin
      // 010 and 011 are not branch conditions
      branch = (f3 != 3'b010) && (f3 != 3'b011);
      legal  = branch;
      case (f3)
        `F3_BEQ:  taken = (a == b);
        `F3_BNE:  taken = (a != b);
        `F3_BLT:  taken = $signed(a) < $signed(b);
        `F3_BGE:  taken = $signed(a) >= $signed(b);
        `F3_BLTU: taken = a < b;
        `F3_BGEU: taken = a >= b;
        default:  taken = 1'b0;
      endcase
    end

    default: ;
  endcase

  exp_illegal = ~legal;
  exp_branch  = branch;
  exp_taken   = branch & taken;
  exp_target  = branch ? pc + imm_b : '0;
  exp_we      = legal && !branch && (rd != 5'd0);
  exp_rd      = exp_we ? rd : 5'd0;
  // ALU and LUI results show even for rd zero
  exp_data    = (legal && !branch) ? value : '0;
  if (exp_we)
    shadow_regs[rd] = value;
endfunction

`endif

// ==== tb_rv_exec_top.sv ====
// testbench for the RV32I execute subsystem
// clock, reset, random instruction stream, sink back-pressure
// compare process against the reference model
`timescale 1ns/100ps
`include "rv_consts.svh"

module tb_rv_exec_top;

  localparam int num_instr      = 400;
  localparam int timeout_cycles = 200;

  logic              clk_i;
  logic              rst_n_i;
  logic              instr_valid_i;
  logic              instr_ready_o;
  rv_pkg::instr_t    instr_i;
  rv_pkg::word_t     pc_i;
  logic              wb_valid_o;
  logic              wb_ready_i;
  rv_pkg::word_t     wb_pc_o;
  logic              wb_we_o;
  rv_pkg::reg_addr_t wb_rd_o;
  rv_pkg::word_t     wb_data_o;
  logic              wb_branch_o;
  logic              wb_taken_o;
  rv_pkg::word_t     wb_target_o;
  logic              wb_illegal_o;

  // accepted instructions waiting for their outcome
  rv_pkg::instr_t    instr_queue [$];
  rv_pkg::word_t     pc_queue [$];
  int                checked;
  logic              drain;

  // sink phases
  int unsigned       phase_left;
  logic              phase_ready;

  // state carried from one edge to the next
  logic              lat_pending;
  rv_pkg::word_t     lat_pc;
  logic              hold_pending;
  rv_pkg::word_t     held_pc;
  rv_pkg::reg_addr_t held_rd;
  rv_pkg::word_t     held_data;
  rv_pkg::word_t     held_target;
  logic [3:0]        held_flags;

  `include "tb_rv_ref.svh"

  rv_exec_top DUT (.*);

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////

  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////
  // instruction builder
  ////////////////////////////////////////

  function automatic rv_pkg::instr_t build_instr();
    logic [31:0] rnd;
    logic [31:0] word;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  shamt;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int unsigned kind;

    rnd  = $urandom;
    kind = $urandom % 10;
    // x0 to x7 only, so results feed later instructions
    rd   = 5'($urandom % 8);
    rs1  = 5'($urandom % 8);
    rs2  = 5'($urandom % 8);
    f3   = 3'($urandom % 8);
    // shift amounts 0 and 31 come up often
    case ($urandom % 3)
      0:       shamt = 5'd0;
      1:       shamt = 5'd31;
      default: shamt = rnd[24:20];
    endcase
    f7 = rnd[0] ? `F7_ALT : `F7_BASE;

    case (kind)
      0, 1: word = {rnd[31:12], rd, `OPC_LUI};
      2, 3, 4:
      begin
        // alternate funct7 only on add/sub and the right shifts
        if (f3 != `F3_ADD_SUB && f3 != `F3_SRL_SRA)
          f7 = `F7_BASE;
        word = {f7, rs2, rs1, f3, rd, `OPC_OP};
      end
      5, 6:
      begin
        if (f3 == `F3_SLL)
          word = {`F7_BASE, shamt, rs1, f3, rd, `OPC_OP_IMM};
        else if (f3 == `F3_SRL_SRA)
          word = {f7, shamt, rs1, f3, rd, `OPC_OP_IMM};
        else
          word = {rnd[31:20], rs1, f3, rd, `OPC_OP_IMM};
      end
      7, 8:
      begin
        // 010 and 011 folded onto BLTU and BGEU
        f3   = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
        word = {rnd[31:25], rs2, rs1, f3, rnd[11:7], `OPC_BRANCH};
      end
      default:
      begin
        // unsupported words: load, multiply, reserved branch, JAL
        case (rnd[2:1])
          2'd0:    word = {rnd[31:12], rd, 7'b0000011};
          2'd1:    word = {7'b0000001, rs2, rs1, f3, rd, `OPC_OP};
          2'd2:    word = {rnd[31:25], rs2, rs1, 3'b010, rnd[11:7], `OPC_BRANCH};
          default: word = {rnd[31:12], rd, 7'b1101111};
        endcase
      end
    endcase
    build_instr = word;
  endfunction

  ////////////////////////////////////////
  // sink ready, random phases
  ////////////////////////////////////////

  always @(posedge clk_i)
  begin : sink_phases
    #1;
    if (phase_left == 0)
    begin
      // ready two thirds of the time, stalls up to six cycles
      phase_ready = ($urandom % 3) != 0;
      phase_left  = 1 + $urandom % 6;
    end
    phase_left--;
    wb_ready_i = phase_ready | drain;
  end

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  always @(posedge clk_i)
  begin : compare_outcomes
    rv_pkg::instr_t exp_instr;
    rv_pkg::word_t  exp_pc;
    logic           e_we;
    logic [4:0]     e_rd;
    logic [31:0]    e_data;
    logic           e_branch;
    logic           e_taken;
    logic [31:0]    e_target;
    logic           e_illegal;

    if (rst_n_i)
    begin
      // accepted on the previous edge, outcome must be up now
      if (lat_pending)
      begin
        check_value("wb_valid_o", 32'd1, 32'(wb_valid_o));
        check_value("wb_pc_o", lat_pc, wb_pc_o);
      end
      // stalled on the previous edge, nothing may move
      if (hold_pending)
      begin
        check_value("wb_valid_o", 32'd1, 32'(wb_valid_o));
        check_value("wb_pc_o", held_pc, wb_pc_o);
        check_value("wb_rd_o", 32'(held_rd), 32'(wb_rd_o));
        check_value("wb_data_o", held_data, wb_data_o);
        check_value("wb_target_o", held_target, wb_target_o);
        check_value("{wb_we_o,wb_branch_o,wb_taken_o,wb_illegal_o}", 32'(held_flags),
                    32'({wb_we_o, wb_branch_o, wb_taken_o, wb_illegal_o}));
      end
      if (wb_valid_o && !wb_ready_i)
        check_value("instr_ready_o", 32'd0, 32'(instr_ready_o));

      if (wb_valid_o && wb_ready_i)
      begin
        if (instr_queue.size() == 0)
        begin
          $display("an outcome at pc %h arrived with no instruction pending", wb_pc_o);
          stop_on_error();
        end
        else
        begin
          exp_instr = instr_queue.pop_front();
          exp_pc    = pc_queue.pop_front();
          predict_outcome(exp_instr, exp_pc, e_we, e_rd, e_data, e_branch, e_taken,
                          e_target, e_illegal);
          check_value("wb_pc_o", exp_pc, wb_pc_o);
          check_value("wb_we_o", 32'(e_we), 32'(wb_we_o));
          check_value("wb_rd_o", 32'(e_rd), 32'(wb_rd_o));
          check_value("wb_data_o", e_data, wb_data_o);
          check_value("wb_branch_o", 32'(e_branch), 32'(wb_branch_o));
          check_value("wb_taken_o", 32'(e_taken), 32'(wb_taken_o));
          check_value("wb_target_o", e_target, wb_target_o);
          check_value("wb_illegal_o", 32'(e_illegal), 32'(wb_illegal_o));
          checked++;
        end
      end

      // handshake of this edge, for the next one
      lat_pending = instr_valid_i && instr_ready_o;
      if (lat_pending)
      begin
        instr_queue.push_back(instr_i);
        pc_queue.push_back(pc_i);
        lat_pc = pc_i;
      end
      hold_pending = wb_valid_o && !wb_ready_i;
      held_pc      = wb_pc_o;
      held_rd      = wb_rd_o;
      held_data    = wb_data_o;
      held_target  = wb_target_o;
      held_flags   = {wb_we_o, wb_branch_o, wb_taken_o, wb_illegal_o};
    end
  end

  ////////////////////////////////////////
  // reset and instruction driver
  ////////////////////////////////////////

  initial
  begin : main_sequence
    rv_pkg::word_t next_pc;
    int            waited;

    void'($urandom(11625));
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    wb_ready_i    = 1'b0;
    drain         = 1'b0;
    checked       = 0;
    phase_left    = 0;
    phase_ready   = 1'b0;
    lat_pending   = 1'b0;
    hold_pending  = 1'b0;
    clear_shadow();
    next_pc = 32'h0000_1000;

    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_value("wb_valid_o", 32'd0, 32'(wb_valid_o));
    check_value("instr_ready_o", 32'd1, 32'(instr_ready_o));

    for (int n = 0; n < num_instr; n++)
    begin
      // idle gap now and then
      if ($urandom % 6 == 0)
      begin
        instr_valid_i = 1'b0;
        @(posedge clk_i);
        #1;
      end
      instr_valid_i = 1'b1;
      instr_i       = build_instr();
      pc_i          = next_pc;
      next_pc       = next_pc + 4;
      waited        = 0;
      do
      begin
        @(posedge clk_i);
        waited++;
        if (waited > timeout_cycles)
        begin
          $display("timeout: the instruction at pc %h was never accepted", pc_i);
          stop_on_error();
        end
      end
      while (!instr_ready_o);
      #1;
    end

    // sink forced ready so the last outcomes drain
    instr_valid_i = 1'b0;
    drain         = 1'b1;
    waited        = 0;
    while (checked < num_instr)
    begin
      @(posedge clk_i);
      waited++;
      if (waited > timeout_cycles)
      begin
        $display("timeout: only %0d of %0d outcomes arrived", checked, num_instr);
        stop_on_error();
      end
    end
    repeat (4) @(posedge clk_i);

    if (instr_queue.size() == 0 && !wb_valid_o)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      $display("outcomes were left over after the last instruction");
      stop_on_error();
    end
  end

endmodule

// ==== project.f ====
+incdir+.
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_commit_stage.sv
rv_exec_top.sv
tb_rv_exec_top.sv

// ==== Makefile ====
# Verilator flow for the RV32I execute subsystem
# make lint, make sim, make clean

TB_TOP := tb_rv_exec_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module rv_exec_top
	verilator --lint-only --timing -f project.f --top-module $(TB_TOP)

# the log decides pass or fail
sim:
	verilator --binary --timing -f project.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
